/* icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// byte offset within a line, 32-byte lines
`define ICACHE_LEN_LINE 5

// set index, 128 sets per way
`define ICACHE_LEN_INDEX 7

// whatever is left of the 32-bit address
`define ICACHE_LEN_TAG (32 - `ICACHE_LEN_LINE - `ICACHE_LEN_INDEX)

// words per line, also the burst length of a fill
`define ICACHE_NR_WORDS (1 << (`ICACHE_LEN_LINE - 2))

`endif

/* icache_pkg.sv */
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    // address split as the arrays see it
    typedef struct packed {
        logic [`ICACHE_LEN_TAG-1:0]   tag;
        logic [`ICACHE_LEN_INDEX-1:0] index;
        logic [`ICACHE_LEN_LINE-3:0]  word;
        logic [1:0]                   byte_ofs;
    } icache_addr_fields_t;

    // raw form for the memory port, field form for the arrays
    typedef union packed {
        logic [31:0]         raw;
        icache_addr_fields_t f;
    } icache_addr_u;

    // lookup stage register
    typedef struct packed {
        logic         en;
        logic         no_cache;
        icache_addr_u addr;
        logic [1:0]   valid;
        logic         lru;
    } icache_req_t;

    // valid/lru write from refill, lru names the next victim
    typedef struct packed {
        logic                         we;
        logic [`ICACHE_LEN_INDEX-1:0] index;
        logic                         way;
        logic                         set_valid;
        logic                         lru;
    } icache_upd_t;

endpackage

`default_nettype wire

/* icache_sdp_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_sdp_ram #(
    parameter int DW = 32,
    parameter int AW = 10
) (
    input  wire           clk,
    input  wire           i_we,
    input  wire  [AW-1:0] i_waddr,
    input  wire  [DW-1:0] i_wdata,
    input  wire           i_re,
    input  wire  [AW-1:0] i_raddr,
    output logic [DW-1:0] o_rdata
);

    logic [DW-1:0] mem [2**AW];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // read-before-write on an address collision
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

`default_nettype wire

/* icache_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_lookup (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire  icache_pkg::icache_addr_u           i_inst_addr,
    input  wire                                      i_inst_en,
    input  wire                                      i_no_cache,
    input  wire                                      i_hold,
    input  wire                                      i_stall,
    input  wire  icache_pkg::icache_upd_t            i_upd,
    input  wire  [1:0][`ICACHE_LEN_TAG-1:0]          i_way_tag,
    input  wire  [1:0][31:0]                         i_way_data,
    output logic                                     o_capture,
    output icache_pkg::icache_req_t                  o_req,
    output logic                                     o_hit,
    output logic                                     o_hit_way,
    output logic [31:0]                              o_hit_data
);
    import icache_pkg::*;

    localparam int NR_SETS = 1 << `ICACHE_LEN_INDEX;

    logic [1:0]  valid_q [NR_SETS];
    logic        lru_q [NR_SETS];
    icache_req_t req_q;
    logic [1:0]  valid_rd;
    logic        lru_rd;
    logic [1:0]  way_hit;

    assign o_capture = ~i_stall & ~i_hold;

    // same-cycle update from refill is bypassed into the read
    always_comb begin
        valid_rd = valid_q[i_inst_addr.f.index];
        lru_rd   = lru_q[i_inst_addr.f.index];
        if (i_upd.we && i_upd.index == i_inst_addr.f.index) begin
            if (i_upd.set_valid) begin
                valid_rd[i_upd.way] = 1'b1;
            end
            lru_rd = i_upd.lru;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (o_capture) begin
            req_q.en       <= i_inst_en;
            req_q.no_cache <= i_no_cache;
            req_q.addr     <= i_inst_addr;
            req_q.valid    <= valid_rd;
            req_q.lru      <= lru_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NR_SETS; s++) begin
                valid_q[s] <= 2'b00;
                lru_q[s]   <= 1'b0;
            end
        end else if (i_upd.we) begin
            if (i_upd.set_valid) begin
                valid_q[i_upd.index][i_upd.way] <= 1'b1;
            end
            lru_q[i_upd.index] <= i_upd.lru;
        end
    end

    // tag compare against ram output of the captured fetch
    assign way_hit[0] = req_q.valid[0] & (i_way_tag[0] == req_q.addr.f.tag);
    assign way_hit[1] = req_q.valid[1] & (i_way_tag[1] == req_q.addr.f.tag);

    assign o_hit      = req_q.en & ~req_q.no_cache & (|way_hit);
    assign o_hit_way  = way_hit[1];
    assign o_hit_data = i_way_data[way_hit[1]];
    assign o_req      = req_q;

endmodule

`default_nettype wire

/* icache_refill.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_refill (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire  icache_pkg::icache_req_t        i_req,
    input  wire                                  i_hit,
    input  wire                                  i_hit_way,
    output logic [31:0]                          o_araddr,
    output logic [7:0]                           o_arlen,
    output logic [2:0]                           o_arsize,
    output logic                                 o_arvalid,
    input  wire                                  i_arready,
    input  wire  [31:0]                          i_rdata,
    input  wire                                  i_rvalid,
    input  wire                                  i_rlast,
    output logic                                 o_rready,
    output logic                                 o_stall,
    output logic                                 o_fwd_valid,
    output logic [31:0]                          o_fwd_data,
    output logic [1:0]                           o_ram_we,
    output logic [`ICACHE_LEN_INDEX-1:0]         o_ram_index,
    output logic [`ICACHE_LEN_LINE-3:0]          o_ram_word,
    output icache_pkg::icache_upd_t              o_upd
);
    import icache_pkg::*;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_UNCACHED = 2'd1;
    localparam logic [1:0] ST_FILL     = 2'd2;

    logic [1:0]                  state;
    logic                        victim;
    logic [`ICACHE_LEN_LINE-3:0] beat_cnt;
    logic                        beat;
    logic                        start;
    icache_addr_u                line_addr;

    assign beat  = o_rready & i_rvalid;
    // forward cycle still holds the old request, so no new miss then
    assign start = (state == ST_IDLE) & i_req.en & ~i_hit & ~o_fwd_valid;

    always_comb begin
        line_addr            = i_req.addr;
        line_addr.f.word     = '0;
        line_addr.f.byte_ofs = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            o_arvalid   <= 1'b0;
            o_rready    <= 1'b0;
            o_fwd_valid <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            o_fwd_valid <= 1'b0;
            if (o_arvalid && i_arready) begin
                o_arvalid <= 1'b0;
                o_rready  <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        o_arvalid <= 1'b1;
                        beat_cnt  <= '0;
                        state     <= i_req.no_cache ? ST_UNCACHED : ST_FILL;
                    end
                end
                ST_UNCACHED: begin
                    if (beat) begin
                        o_rready    <= 1'b0;
                        o_fwd_valid <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                ST_FILL: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (i_rlast) begin
                            o_rready    <= 1'b0;
                            o_fwd_valid <= 1'b1;
                            state       <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // burst request and forwarded word
    always_ff @(posedge clk) begin
        if (start) begin
            o_araddr <= i_req.no_cache ? i_req.addr.raw : line_addr.raw;
            o_arlen  <= i_req.no_cache ? 8'd0 : 8'(`ICACHE_NR_WORDS - 1);
            victim   <= i_req.lru;
        end
        if (beat && (state == ST_UNCACHED || beat_cnt == i_req.addr.f.word)) begin
            o_fwd_data <= i_rdata;
        end
    end

    // always full 32-bit beats
    assign o_arsize = 3'd2;

    assign o_ram_we    = (beat && state == ST_FILL) ? (victim ? 2'b10 : 2'b01) : 2'b00;
    assign o_ram_index = i_req.addr.f.index;
    assign o_ram_word  = beat_cnt;

    assign o_stall = (state != ST_IDLE) | start;

    // mark the way just used as most recent
    always_comb begin
        o_upd       = '0;
        o_upd.index = i_req.addr.f.index;
        if (state == ST_FILL && beat && i_rlast) begin
            o_upd.we        = 1'b1;
            o_upd.way       = victim;
            o_upd.set_valid = 1'b1;
            o_upd.lru       = ~victim;
        end else if (state == ST_IDLE && i_hit) begin
            o_upd.we  = 1'b1;
            o_upd.way = i_hit_way;
            o_upd.lru = ~i_hit_way;
        end
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_top (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] i_inst_addr,
    input  wire         i_inst_en,
    input  wire         i_no_cache,
    input  wire         i_hold,
    output logic        o_stall,
    output logic [31:0] o_inst_rdata,
    output logic [31:0] o_araddr,
    output logic [7:0]  o_arlen,
    output logic [2:0]  o_arsize,
    output logic        o_arvalid,
    input  wire         i_arready,
    input  wire  [31:0] i_rdata,
    input  wire         i_rvalid,
    input  wire         i_rlast,
    output logic        o_rready
);
    import icache_pkg::*;

    localparam int DATA_AW = `ICACHE_LEN_INDEX + `ICACHE_LEN_LINE - 2;

    icache_addr_u                   fetch_addr;
    icache_req_t                    req;
    icache_upd_t                    upd;
    logic                           capture;
    logic                           hit;
    logic                           hit_way;
    logic [31:0]                    hit_data;
    logic                           fwd_valid;
    logic [31:0]                    fwd_data;
    logic [1:0]                     ram_we;
    logic [`ICACHE_LEN_INDEX-1:0]   ram_index;
    logic [`ICACHE_LEN_LINE-3:0]    ram_word;
    logic [1:0][`ICACHE_LEN_TAG-1:0] way_tag;
    logic [1:0][31:0]               way_data;

    assign fetch_addr = i_inst_addr;

    icache_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .i_inst_addr(fetch_addr),
        .i_inst_en  (i_inst_en),
        .i_no_cache (i_no_cache),
        .i_hold     (i_hold),
        .i_stall    (o_stall),
        .i_upd      (upd),
        .i_way_tag  (way_tag),
        .i_way_data (way_data),
        .o_capture  (capture),
        .o_req      (req),
        .o_hit      (hit),
        .o_hit_way  (hit_way),
        .o_hit_data (hit_data)
    );

    icache_refill u_refill (
        .clk        (clk),
        .rst        (rst),
        .i_req      (req),
        .i_hit      (hit),
        .i_hit_way  (hit_way),
        .o_araddr   (o_araddr),
        .o_arlen    (o_arlen),
        .o_arsize   (o_arsize),
        .o_arvalid  (o_arvalid),
        .i_arready  (i_arready),
        .i_rdata    (i_rdata),
        .i_rvalid   (i_rvalid),
        .i_rlast    (i_rlast),
        .o_rready   (o_rready),
        .o_stall    (o_stall),
        .o_fwd_valid(fwd_valid),
        .o_fwd_data (fwd_data),
        .o_ram_we   (ram_we),
        .o_ram_index(ram_index),
        .o_ram_word (ram_word),
        .o_upd      (upd)
    );

    // tag is rewritten on every beat of the fill, harmless
    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_sdp_ram #(
            .DW(`ICACHE_LEN_TAG),
            .AW(`ICACHE_LEN_INDEX)
        ) u_tag_ram (
            .clk    (clk),
            .i_we   (ram_we[w]),
            .i_waddr(ram_index),
            .i_wdata(req.addr.f.tag),
            .i_re   (capture),
            .i_raddr(fetch_addr.f.index),
            .o_rdata(way_tag[w])
        );

        icache_sdp_ram #(
            .DW(32),
            .AW(DATA_AW)
        ) u_data_ram (
            .clk    (clk),
            .i_we   (ram_we[w]),
            .i_waddr({ram_index, ram_word}),
            .i_wdata(i_rdata),
            .i_re   (capture),
            .i_raddr({fetch_addr.f.index, fetch_addr.f.word}),
            .o_rdata(way_data[w])
        );
    end

    assign o_inst_rdata = fwd_valid ? fwd_data : hit_data;

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    input  wire  i_reset_req,
    output logic clk,
    output logic rst
);

    int rst_cnt;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset held for 5 rising edges, restarted by a request
    initial begin
        rst     = 1'b1;
        rst_cnt = 5;
        forever begin
            @(posedge clk);
            if (i_reset_req) begin
                rst_cnt = 5;
            end else if (rst_cnt != 0) begin
                rst_cnt = rst_cnt - 1;
            end
            #1 rst = (rst_cnt != 0);
        end
    end

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] i_araddr,
    input  wire  [7:0]  i_arlen,
    input  wire         i_arvalid,
    output logic        o_arready,
    output logic [31:0] o_rdata,
    output logic        o_rvalid,
    output logic        o_rlast,
    input  wire         i_rready,
    output logic [31:0] o_ar_count,
    output logic [31:0] o_last_addr,
    output logic [7:0]  o_last_len
);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_ADDR = 2'd1;
    localparam logic [1:0] M_DATA = 2'd2;

    logic [31:0] lfsr;
    logic [1:0]  m_state;
    logic [1:0]  wait_cnt;
    logic [31:0] burst_addr;
    logic [7:0]  burst_len;
    logic [7:0]  beat_idx;
    logic [31:0] ar_count;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        lfsr        = 32'he940;
        m_state     = M_IDLE;
        wait_cnt    = '0;
        burst_addr  = '0;
        burst_len   = '0;
        beat_idx    = '0;
        ar_count    = '0;
        o_arready   = 1'b0;
        o_rdata     = '0;
        o_rvalid    = 1'b0;
        o_rlast     = 1'b0;
        o_ar_count  = '0;
        o_last_addr = '0;
        o_last_len  = '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                m_state = M_IDLE;
            end else begin
                case (m_state)
                    M_IDLE: begin
                        if (i_arvalid) begin
                            burst_addr = i_araddr;
                            burst_len  = i_arlen;
                            wait_cnt   = 2'(take_bits(2));
                            m_state    = M_ADDR;
                        end
                    end
                    M_ADDR: begin
                        if (o_arready && i_arvalid) begin
                            ar_count = ar_count + 1;
                            beat_idx = '0;
                            wait_cnt = 2'(take_bits(1));
                            m_state  = M_DATA;
                        end else if (wait_cnt != 0) begin
                            wait_cnt = wait_cnt - 1'b1;
                        end
                    end
                    M_DATA: begin
                        if (o_rvalid && i_rready) begin
                            if (o_rlast) begin
                                m_state = M_IDLE;
                            end else begin
                                beat_idx = beat_idx + 1'b1;
                                wait_cnt = 2'(take_bits(1));
                            end
                        end else if (wait_cnt != 0) begin
                            wait_cnt = wait_cnt - 1'b1;
                        end
                    end
                    default: begin
                        m_state = M_IDLE;
                    end
                endcase
            end
            #1;
            o_arready   = (m_state == M_ADDR) && (wait_cnt == 0);
            o_rvalid    = (m_state == M_DATA) && (wait_cnt == 0);
            o_rlast     = o_rvalid && (beat_idx == burst_len);
            o_rdata     = mem_word(burst_addr + {22'd0, beat_idx, 2'b00});
            o_ar_count  = ar_count;
            o_last_addr = burst_addr;
            o_last_len  = burst_len;
        end
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache;

    localparam int          TIMEOUT   = 200;
    localparam int          NR_TESTS  = 17;
    localparam logic [31:0] LINE_MASK = 32'hffff_ffe0;
    localparam logic [7:0]  FILL_LEN  = 8'd7;
    localparam logic [2:0]  WORD_SIZE = 3'd2;

    typedef struct packed {
        logic [31:0] addr;
        logic        no_cache;
        logic [1:0]  incr;
        logic        do_reset;
    } entry_t;

    // tags 1, 2 and 3 all map to set 5
    localparam entry_t TESTS [NR_TESTS] = '{
        '{32'h0000_10a4, 1'b0, 2'd1, 1'b0},
        '{32'h0000_10a0, 1'b0, 2'd0, 1'b0},
        '{32'h0000_10bc, 1'b0, 2'd0, 1'b0},
        '{32'h0000_20a8, 1'b0, 2'd1, 1'b0},
        '{32'h0000_10a0, 1'b0, 2'd0, 1'b0},
        '{32'h0000_20b0, 1'b0, 2'd0, 1'b0},
        // way 0 (tag 1) is lru here
        '{32'h0000_30a0, 1'b0, 2'd1, 1'b0},
        '{32'h0000_20a4, 1'b0, 2'd0, 1'b0},
        '{32'h0000_30ac, 1'b0, 2'd0, 1'b0},
        '{32'h0000_10a0, 1'b0, 2'd1, 1'b0},
        '{32'h0000_20a0, 1'b0, 2'd1, 1'b0},
        '{32'h0000_4124, 1'b1, 2'd1, 1'b0},
        '{32'h0000_4124, 1'b1, 2'd1, 1'b0},
        '{32'h0000_4124, 1'b0, 2'd1, 1'b0},
        '{32'h0000_4128, 1'b0, 2'd0, 1'b0},
        '{32'h0000_4128, 1'b0, 2'd1, 1'b1},
        '{32'h0000_20a0, 1'b0, 2'd1, 1'b0}
    };

    logic        clk;
    logic        rst;
    logic        reset_req;
    logic [31:0] inst_addr;
    logic        inst_en;
    logic        no_cache;
    logic        hold;
    logic        stall;
    logic [31:0] inst_rdata;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rlast;
    logic        rready;
    logic [31:0] ar_count;
    logic [31:0] last_addr;
    logic [7:0]  last_len;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    logic        timed_out;

    tb_clock_gen u_clock_gen (
        .i_reset_req(reset_req),
        .clk        (clk),
        .rst        (rst)
    );

    icache_top DUT (
        .clk         (clk),
        .rst         (rst),
        .i_inst_addr (inst_addr),
        .i_inst_en   (inst_en),
        .i_no_cache  (no_cache),
        .i_hold      (hold),
        .o_stall     (stall),
        .o_inst_rdata(inst_rdata),
        .o_araddr    (araddr),
        .o_arlen     (arlen),
        .o_arsize    (arsize),
        .o_arvalid   (arvalid),
        .i_arready   (arready),
        .i_rdata     (rdata),
        .i_rvalid    (rvalid),
        .i_rlast     (rlast),
        .o_rready    (rready)
    );

    tb_axi_mem u_mem (
        .clk        (clk),
        .rst        (rst),
        .i_araddr   (araddr),
        .i_arlen    (arlen),
        .i_arvalid  (arvalid),
        .o_arready  (arready),
        .o_rdata    (rdata),
        .o_rvalid   (rvalid),
        .o_rlast    (rlast),
        .i_rready   (rready),
        .o_ar_count (ar_count),
        .o_last_addr(last_addr),
        .o_last_len (last_len)
    );

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        err_cnt++;
    endtask

    // outputs are sampled on the falling edge
    task automatic wait_stall_low(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (stall && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (!stall) else begin
            $display("timeout: o_stall still high after %0d cycles at %0d ns", TIMEOUT, $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_reset_release;
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rst && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (!rst) else begin
            $display("timeout: reset never released at %0d ns", $time);
            timed_out = 1'b1;
        end
    endtask

    // uncached read in flight when the reset arrives
    task automatic apply_reset(input logic [31:0] addr);
        @(posedge clk);
        #1;
        inst_addr = addr;
        inst_en   = 1'b1;
        no_cache  = 1'b1;
        @(posedge clk);
        #1;
        inst_en   = 1'b0;
        no_cache  = 1'b0;
        reset_req = 1'b1;
        @(posedge clk);
        #1 reset_req = 1'b0;
        @(negedge clk);
        assert (arvalid && stall) else begin
            $display("no read in flight when the reset was requested at %0d ns", $time);
            err_cnt++;
        end
        wait_reset_release();
        assert (!arvalid) else report_mismatch("o_arvalid", 32'(arvalid), 32'd0);
        assert (!stall) else report_mismatch("o_stall", 32'(stall), 32'd0);
    endtask

    task automatic run_test(input int n);
        entry_t      e;
        int          cycles;
        int          err_before;
        logic [31:0] count_before;
        logic [31:0] exp_data;
        logic [31:0] exp_araddr;
        logic [7:0]  exp_arlen;
        string       kind;
        e          = TESTS[n];
        err_before = err_cnt;
        exp_data   = expected_word(e.addr);
        exp_araddr = e.no_cache ? e.addr : (e.addr & LINE_MASK);
        exp_arlen  = e.no_cache ? 8'd0 : FILL_LEN;
        kind       = e.no_cache ? "uncached" : ((e.incr != 0) ? "miss" : "hit");
        if (e.do_reset) begin
            apply_reset(e.addr);
        end
        @(posedge clk);
        #1;
        inst_addr = e.addr;
        inst_en   = 1'b1;
        no_cache  = e.no_cache;
        // taken at the next edge with o_stall low
        wait_stall_low(cycles);
        count_before = ar_count;
        @(posedge clk);
        #1;
        inst_en  = 1'b0;
        no_cache = 1'b0;
        wait_stall_low(cycles);
        if (!timed_out) begin
            assert (inst_rdata == exp_data) else
                report_mismatch("o_inst_rdata", inst_rdata, exp_data);
            assert (ar_count - count_before == 32'(e.incr)) else
                report_mismatch("burst count", ar_count - count_before, 32'(e.incr));
            if (e.incr == 2'd0) begin
                assert (cycles == 0) else begin
                    $display("hit at %h stalled for %0d cycles", e.addr, cycles);
                    err_cnt++;
                end
            end else begin
                assert (last_addr == exp_araddr) else
                    report_mismatch("o_araddr", last_addr, exp_araddr);
                assert (last_len == exp_arlen) else
                    report_mismatch("o_arlen", {24'd0, last_len}, {24'd0, exp_arlen});
                assert (arsize == WORD_SIZE) else
                    report_mismatch("o_arsize", {29'd0, arsize}, {29'd0, WORD_SIZE});
            end
        end
        if (err_cnt == err_before && !timed_out) begin
            pass_cnt++;
            $display("test %0d: %s at %h passed", n, kind, e.addr);
        end else begin
            fail_cnt++;
            $display("test %0d: %s at %h failed", n, kind, e.addr);
        end
    endtask

    initial begin
        inst_addr = '0;
        inst_en   = 1'b0;
        no_cache  = 1'b0;
        hold      = 1'b0;
        reset_req = 1'b0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;
        wait_reset_release();
        for (int n = 0; n < NR_TESTS && !timed_out; n++) begin
            run_test(n);
        end
        $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
                 fail_cnt);
        if (fail_cnt == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
icache_pkg.sv
icache_sdp_ram.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
tb_clock_gen.sv
tb_axi_mem.sv
tb_icache.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_icache
FILELIST   = verilog.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
LOG        = sim.log
PASS_MSG   = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
